//--- source/spi_rx_pkg.sv
package spi_rx_pkg;

	////////////////////////////////////////
	// Byte framing on the SPI side
	////////////////////////////////////////

	// Bits per SPI byte, MSB first
	localparam int byte_w = 8;

	// One received byte
	typedef logic [byte_w-1:0] byte_t;

	// Bit position within a byte
	typedef logic [$clog2(byte_w)-1:0] bit_cnt_t;

	////////////////////////////////////////
	// Clock crossing buffer
	////////////////////////////////////////

	localparam int fifo_depth = 16; // Entries, power of two
	localparam int addr_w = $clog2(fifo_depth); // Memory address bits

	// Binary or Gray pointer plus one wrap bit
	typedef logic [addr_w:0] ptr_t;

endpackage

//--- source/spi_bit_assembler.sv
module spi_bit_assembler (
	input  logic              rst_n,
	input  logic              scl,      // SPI clock, mode 0
	input  logic              cs_n,
	input  logic              sda,      // Serial data in
	input  logic              full,     // From FIFO write side
	output logic              wr_en,
	output spi_rx_pkg::byte_t wr_data,
	output logic              overflow  // Sticky until reset
);

	////////////////////////////////////////
	// Bit collection
	////////////////////////////////////////

	spi_rx_pkg::bit_cnt_t               bit_cnt; // Next bit position
	logic [spi_rx_pkg::byte_w-2:0]      shift_q; // First seven bits of the byte
	logic                               byte_done;

	// Eighth bit being sampled on this edge
	assign byte_done = ~cs_n & (&bit_cnt);

	// Position counter, restarts with every frame
	always_ff @(posedge scl or negedge rst_n) begin
		if (~rst_n) begin
			bit_cnt <= '0;
		end else if (cs_n) begin
			bit_cnt <= '0; // Partial byte discarded here
		end else begin
			bit_cnt <= bit_cnt + spi_rx_pkg::bit_cnt_t'(1); // Wraps after bit 7
		end
	end

	// Shift register for the leading bits
	always_ff @(posedge scl) begin
		if (~cs_n) begin
			shift_q <= {shift_q[spi_rx_pkg::byte_w-3:0], sda};
		end
	end

	////////////////////////////////////////
	// Hand-off to the FIFO
	////////////////////////////////////////

	// Last bit is taken live from sda
	always_ff @(posedge scl) begin
		if (byte_done) begin
			wr_data <= {shift_q, sda};
		end
	end

	// Write strobe lands in the cycle after the eighth edge
	always_ff @(posedge scl or negedge rst_n) begin
		if (~rst_n) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= byte_done & ~full; // Byte dropped when full
		end
	end

	// Lost byte flag
	always_ff @(posedge scl or negedge rst_n) begin
		if (~rst_n) begin
			overflow <= 1'b0;
		end else if (byte_done & full) begin
			overflow <= 1'b1;
		end
	end

	// full only rises from a write of ours, so the decision one edge early stays valid
	a_full_rises_on_write: assert property (
		@(posedge scl) disable iff (~rst_n)
		$rose(full) |-> $past(wr_en)
	) else $error("full rose without a write strobe");

endmodule

//--- source/async_byte_fifo.sv
module async_byte_fifo (
	input  logic              rst_n,
	// Write side, SPI clock domain
	input  logic              scl,
	input  logic              wr_en,
	input  spi_rx_pkg::byte_t wr_data,
	output logic              full,
	// Read side
	input  logic              rd_clk,
	input  logic              rd_en,
	output spi_rx_pkg::byte_t rd_data,  // Registered, updates on the pop edge
	output logic              empty
);

	// Binary to Gray, one bit changes per step
	function automatic spi_rx_pkg::ptr_t bin2gray(input spi_rx_pkg::ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	spi_rx_pkg::byte_t mem [spi_rx_pkg::fifo_depth]; // Storage, no reset

	spi_rx_pkg::ptr_t rd_gray; // Read pointer in Gray, crosses into scl

	////////////////////////////////////////
	// Write domain
	////////////////////////////////////////

	spi_rx_pkg::ptr_t wr_bin;
	spi_rx_pkg::ptr_t wr_bin_next;
	spi_rx_pkg::ptr_t wr_gray;
	spi_rx_pkg::ptr_t rq1_rd_gray; // Read pointer, first stage
	spi_rx_pkg::ptr_t rq2_rd_gray; // Read pointer, safe to use

	assign wr_bin_next = wr_bin + spi_rx_pkg::ptr_t'(wr_en);

	always_ff @(posedge scl) begin
		if (wr_en) begin
			mem[wr_bin[spi_rx_pkg::addr_w-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge scl or negedge rst_n) begin
		if (~rst_n) begin
			wr_bin  <= '0;
			wr_gray <= '0;
		end else begin
			wr_bin  <= wr_bin_next;
			wr_gray <= bin2gray(wr_bin_next);
		end
	end

	// Read pointer into scl
	always_ff @(posedge scl or negedge rst_n) begin
		if (~rst_n) begin
			rq1_rd_gray <= '0;
			rq2_rd_gray <= '0;
		end else begin
			rq1_rd_gray <= rd_gray;
			rq2_rd_gray <= rq1_rd_gray;
		end
	end

	// Full when writer is one lap ahead
	// In Gray code that is the top two bits flipped, the rest equal
	assign full = (wr_gray == {~rq2_rd_gray[spi_rx_pkg::addr_w -: 2],
		rq2_rd_gray[spi_rx_pkg::addr_w-2:0]});

	////////////////////////////////////////
	// Read domain
	////////////////////////////////////////

	spi_rx_pkg::ptr_t rd_bin;
	spi_rx_pkg::ptr_t rd_bin_next;
	spi_rx_pkg::ptr_t rd_gray_next;
	spi_rx_pkg::ptr_t wq1_wr_gray; // Write pointer, first stage
	spi_rx_pkg::ptr_t wq2_wr_gray; // Write pointer, safe to use

	assign rd_bin_next  = rd_bin + spi_rx_pkg::ptr_t'(rd_en);
	assign rd_gray_next = bin2gray(rd_bin_next);

	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (~rst_n) begin
			rd_bin  <= '0;
			rd_gray <= '0;
		end else begin
			rd_bin  <= rd_bin_next;
			rd_gray <= rd_gray_next;
		end
	end

	// Write pointer into rd_clk
	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (~rst_n) begin
			wq1_wr_gray <= '0;
			wq2_wr_gray <= '0;
		end else begin
			wq1_wr_gray <= wr_gray;
			wq2_wr_gray <= wq1_wr_gray;
		end
	end

	// Registered empty
	// Built from the next read pointer so a pop counts on its own edge
	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (~rst_n) begin
			empty <= 1'b1;
		end else begin
			empty <= (rd_gray_next == wq2_wr_gray);
		end
	end

	// Output byte register
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_bin[spi_rx_pkg::addr_w-1:0]];
		end
	end

	////////////////////////////////////////
	// Protocol checks on both neighbours
	////////////////////////////////////////

	a_no_write_when_full: assert property (
		@(posedge scl) disable iff (~rst_n)
		wr_en |-> ~full
	) else $error("FIFO written while full");

	a_no_read_when_empty: assert property (
		@(posedge rd_clk) disable iff (~rst_n)
		rd_en |-> ~empty
	) else $error("FIFO read while empty");

endmodule

//--- source/rx_byte_reader.sv
module rx_byte_reader (
	input  logic              rst_n,
	input  logic              rd_clk,
	input  logic              empty,     // Registered in the FIFO
	input  logic              hold,      // Stalls new pops
	input  spi_rx_pkg::byte_t rd_data,
	output logic              rd_en,
	output spi_rx_pkg::byte_t out_data,
	output logic              out_valid  // One cycle per byte
);

	////////////////////////////////////////
	// Pop request
	////////////////////////////////////////

	logic pop_q; // Pop taken on the last edge

	// empty already accounts for the pop on the same edge
	// so rd_en may stay high back to back while bytes remain
	assign rd_en = ~empty & ~hold;

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////

	// Byte shows up with rd_data one edge after rd_en
	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (~rst_n) begin
			pop_q <= 1'b0;
		end else begin
			pop_q <= rd_en;
		end
	end

	assign out_valid = pop_q;
	assign out_data  = rd_data; // FIFO output is already registered

endmodule

//--- source/spi_rx_top.sv
module spi_rx_top (
	input  logic              rst_n,
	// SPI slave inputs
	input  logic              scl,
	input  logic              cs_n,
	input  logic              sda,
	output logic              overflow,   // Sticky, scl domain
	// Read side
	input  logic              rd_clk,
	input  logic              hold,
	output spi_rx_pkg::byte_t out_data,
	output logic              out_valid
);

	// Write side wires
	logic              wr_en;
	spi_rx_pkg::byte_t wr_data;
	logic              full;

	// Read side wires
	logic              rd_en;
	spi_rx_pkg::byte_t rd_data;
	logic              empty;

	////////////////////////////////////////
	// Producer
	////////////////////////////////////////

	spi_bit_assembler u_assembler (
		.rst_n    (rst_n),
		.scl      (scl),
		.cs_n     (cs_n),
		.sda      (sda),
		.full     (full),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.overflow (overflow)
	);

	////////////////////////////////////////
	// Clock crossing
	////////////////////////////////////////

	async_byte_fifo u_fifo (
		.rst_n   (rst_n),
		.scl     (scl),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.full    (full),
		.rd_clk  (rd_clk),
		.rd_en   (rd_en),
		.rd_data (rd_data),
		.empty   (empty)
	);

	////////////////////////////////////////
	// Consumer
	////////////////////////////////////////

	rx_byte_reader u_reader (
		.rst_n     (rst_n),
		.rd_clk    (rd_clk),
		.empty     (empty),
		.hold      (hold),
		.rd_data   (rd_data),
		.rd_en     (rd_en),
		.out_data  (out_data),
		.out_valid (out_valid)
	);

endmodule

//--- tests/spi_rx_tb.sv
module spi_rx_tb;

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	localparam int n_rows = 10;

	// hold patterns per row
	localparam int hold_free   = 0; // Low all the time
	localparam int hold_random = 1; // Random stretches
	localparam int hold_block  = 2; // High for the whole frame

	// One column per field, one entry per frame
	localparam int row_bytes   [n_rows] = '{1, 4, 2, 3, 1, 0, 6, 12, 20, 3};
	localparam int row_partial [n_rows] = '{0, 0, 3, 0, 7, 1, 0, 5, 0, 2}; // Bits before cs_n rises
	localparam int row_hold    [n_rows] = '{0, 0, 0, 0, 0, 0, 1, 1, 2, 0};
	localparam int row_ovf     [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1}; // overflow after the row

	localparam int drain_limit  = 200; // rd_clk cycles
	localparam int quiet_cycles = 20;  // scl cycles with no frame

	////////////////////////////////////////
	// DUT signals
	////////////////////////////////////////

	logic              rst_n;
	logic              scl = 1'b0;
	logic              cs_n;
	logic              sda;
	logic              rd_clk = 1'b0;
	logic              hold;
	logic              overflow;
	spi_rx_pkg::byte_t out_data;
	logic              out_valid;

	// Separate streams for data and hold
	integer data_seed = 32'h5cd96897;
	integer hold_seed = 32'h5cd96897;

	spi_rx_pkg::byte_t exp_q [$]; // Bytes still due on out_data
	spi_rx_pkg::byte_t want;
	int                hold_mode = 0;
	int                stretch;      // rd_clk cycles left in a hold stretch
	int                rand_val;
	logic              hold_seen = 1'b0; // hold as it stood at the last edge

	always #50 scl = ~scl;    // 100 ns
	always #15 rd_clk = ~rd_clk; // 30 ns

	spi_rx_top uut (
		.rst_n     (rst_n),
		.scl       (scl),
		.cs_n      (cs_n),
		.sda       (sda),
		.overflow  (overflow),
		.rd_clk    (rd_clk),
		.hold      (hold),
		.out_data  (out_data),
		.out_valid (out_valid)
	);

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	// Queue empties as the read side takes bytes
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(posedge rd_clk);
			cycles++;
			if (cycles > drain_limit) begin
				$display("Timeout: %0d bytes never arrived on out_data", exp_q.size());
				abort_run();
			end
		end
	endtask

	////////////////////////////////////////
	// SPI driver
	////////////////////////////////////////

	// Called 5 ns after a rising scl edge, returns at the same phase
	task automatic drive_bit(input logic b);
		sda = b;
		@(posedge scl); // DUT samples here
		#5;
	endtask

	task automatic send_byte(input spi_rx_pkg::byte_t value);
		spi_rx_pkg::bit_cnt_t pos;
		pos = '1; // MSB first
		repeat (spi_rx_pkg::byte_w) begin
			drive_bit(value[pos]);
			pos = pos - spi_rx_pkg::bit_cnt_t'(1);
		end
	endtask

	// Stray bits that never make a byte
	task automatic send_partial(input int bits);
		integer rand_word;
		repeat (bits) begin
			rand_word = $random(data_seed);
			drive_bit(rand_word[0]);
		end
	endtask

	task automatic idle_scl(input int cycles);
		repeat (cycles) @(posedge scl);
		#5;
	endtask

	////////////////////////////////////////
	// hold driver, rd_clk domain
	////////////////////////////////////////

	initial begin
		hold = 1'b0;
		stretch = 0;
		forever begin
			@(posedge rd_clk);
			#5;
			if (hold_mode == hold_block) begin
				hold = 1'b1;
			end else if (hold_mode == hold_random) begin
				if (stretch == 0) begin
					rand_val = $random(hold_seed);
					hold = rand_val[0];
					stretch = 1 + ((rand_val >>> 4) & 15); // 1 to 16 cycles
				end
				stretch = stretch - 1;
			end else begin
				hold = 1'b0;
				stretch = 0;
			end
		end
	end

	////////////////////////////////////////
	// Read side checker
	////////////////////////////////////////

	// Falling edge, well away from both drive points
	always @(negedge rd_clk) begin
		if (rst_n) begin
			if (hold_seen) begin
				check_value(32'(out_valid), 32'd0, "out_valid a cycle after hold rose");
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected byte %0h on out_data at %0d ns", out_data, $time);
					abort_run();
				end else begin
					want = exp_q.pop_front();
					check_value(32'(out_data), 32'(want), "out_data");
				end
			end
			hold_seen = hold;
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int                row;
		int                n;
		int                stored;     // Bytes parked in the FIFO during hold
		logic              expect_ovf;
		spi_rx_pkg::byte_t value;

		rst_n = 1'b0;
		cs_n = 1'b1; // Deselected, scl still runs
		sda = 1'b0;
		expect_ovf = 1'b0;

		repeat (10) @(posedge scl);
		#5;
		rst_n = 1'b1;

		// Nothing may come out of an idle line
		idle_scl(quiet_cycles);
		check_value(32'(overflow), 32'd0, "overflow after reset");

		for (row = 0; row < n_rows; row++) begin
			hold_mode = row_hold[row];
			stored = 0;
			idle_scl(2);

			cs_n = 1'b0;
			for (n = 0; n < row_bytes[row]; n++) begin
				value = spi_rx_pkg::byte_t'($random(data_seed));
				// With hold high, only fifo_depth bytes fit
				if (row_hold[row] != hold_block || stored < spi_rx_pkg::fifo_depth) begin
					exp_q.push_back(value);
				end
				stored++;
				send_byte(value);
			end
			send_partial(row_partial[row]);
			cs_n = 1'b1; // Partial byte gone

			hold_mode = hold_free; // Release, let the FIFO empty
			wait_drain();
			idle_scl(4);
			expect_ovf = (row_ovf[row] != 0);
			check_value(32'(overflow), 32'(expect_ovf), "overflow after frame");
		end

		// Late extras or duplicates would show up here
		idle_scl(quiet_cycles);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- compile.f
source/spi_rx_pkg.sv
source/spi_bit_assembler.sv
source/async_byte_fifo.sv
source/rx_byte_reader.sv
source/spi_rx_top.sv
tests/spi_rx_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module spi_rx_tb -o spi_rx_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/spi_rx_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
